/* hw/bus_arbiter.sv */
////////////////////////////////////////////////////////////////////////////
// fixed priority arbiter between the request slots and the memory bus
// the highest requesting index wins, one access at a time
// memory read data and the done pulse are routed back to the owner
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mem_ctrl_params.svh"

module bus_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    // slot side
    input  logic [`MC_NUM_REQ-1:0] slot_req,
    input  logic [`MC_NUM_REQ-1:0] slot_ren,
    input  logic [`MC_NUM_REQ-1:0] slot_wen,
    input  mem_ctrl_pkg::addr_t    slot_addr    [`MC_NUM_REQ],
    input  mem_ctrl_pkg::word_t    slot_wdata   [`MC_NUM_REQ],
    input  mem_ctrl_pkg::byte_en_t slot_byte_en [`MC_NUM_REQ],
    output logic [`MC_NUM_REQ-1:0] slot_gnt,
    output logic [`MC_NUM_REQ-1:0] slot_done,
    output mem_ctrl_pkg::word_t    rd_word,
    // memory bus
    output logic                   mem_ren,
    output logic                   mem_wen,
    output mem_ctrl_pkg::addr_t    mem_addr,
    output mem_ctrl_pkg::word_t    mem_wdata,
    output mem_ctrl_pkg::byte_en_t mem_byte_en,
    input  logic                   mem_busy,
    input  mem_ctrl_pkg::word_t    mem_rdata
);
    import mem_ctrl_pkg::*;

    localparam int N     = `MC_NUM_REQ;
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    // owner tracking
    logic             active;
    logic [IDX_W-1:0] owner;
    logic [IDX_W-1:0] pick;
    logic             pick_vld;
    logic             grant_now;
    logic             xfer_done;

    // copy of the owner's access that drives the memory bus
    logic     own_ren;
    logic     own_wen;
    addr_t    own_addr;
    word_t    own_wdata;
    byte_en_t own_byte_en;

    // priority pick
    // later iterations overwrite so the top index wins
    always_comb begin
        pick     = '0;
        pick_vld = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (slot_req[i]) begin
                pick     = IDX_W'(i);
                pick_vld = 1'b1;
            end
        end
    end

    // new owner only while the bus is free
    assign grant_now = !active & pick_vld;

    // first cycle with a request up and memory not busy
    assign xfer_done = (own_ren | own_wen) & ~mem_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            owner    <= '0;
            own_ren  <= 1'b0;
            own_wen  <= 1'b0;
            slot_gnt <= '0;
        end else begin
            // grant is a single cycle pulse
            slot_gnt <= '0;
            if (grant_now) begin
                active   <= 1'b1;
                owner    <= pick;
                own_ren  <= slot_ren[pick];
                own_wen  <= slot_wen[pick];
                slot_gnt <= N'(1) << pick;
            end else if (xfer_done) begin
                // bus free again so the next grant can follow
                active  <= 1'b0;
                own_ren <= 1'b0;
                own_wen <= 1'b0;
            end
        end
    end

    // access payload copied at grant
    always_ff @(posedge clk) begin
        if (grant_now) begin
            own_addr    <= slot_addr[pick];
            own_wdata   <= slot_wdata[pick];
            own_byte_en <= slot_byte_en[pick];
        end
    end

    // done goes to the owning slot only
    always_comb begin
        slot_done = '0;
        if (xfer_done) begin
            slot_done[owner] = 1'b1;
        end
    end

    // read data is valid in the done cycle only
    assign rd_word = mem_rdata;

    assign mem_ren     = own_ren;
    assign mem_wen     = own_wen;
    assign mem_addr    = own_addr;
    assign mem_wdata   = own_wdata;
    assign mem_byte_en = own_byte_en;

    // a grant is one-hot and puts the access on the bus in the same cycle
    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        (slot_gnt != '0) |-> ($onehot(slot_gnt) && (mem_ren || mem_wen)));

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_ren && mem_wen));

    // request held steady through wait states
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ((mem_ren || mem_wen) && mem_busy) |=>
            ($stable(mem_ren) && $stable(mem_wen) && $stable(mem_addr) &&
             $stable(mem_wdata) && $stable(mem_byte_en)));

endmodule

/* hw/mem_ctrl_params.svh */
////////////////////////////////////////////////////////////////////////////
// bus widths and requester count for the shared memory controller
// included by the package and by every RTL file that sizes a port
////////////////////////////////////////////////////////////////////////////
`ifndef MEM_CTRL_PARAMS_SVH
`define MEM_CTRL_PARAMS_SVH

`define MC_ADDR_W  32
`define MC_DATA_W  32
// the data port at index 1 outranks the fetch port at index 0
`define MC_NUM_REQ 2

`endif

/* hw/mem_ctrl_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared types for the memory controller RTL
// ports refer to these by scoped name, module bodies import them
////////////////////////////////////////////////////////////////////////////
`include "mem_ctrl_params.svh"

package mem_ctrl_pkg;

    // byte address on every bus
    typedef logic [`MC_ADDR_W-1:0] addr_t;

    // one data word
    typedef logic [`MC_DATA_W-1:0] word_t;

    // one lane enable per byte of a word
    typedef logic [(`MC_DATA_W/8)-1:0] byte_en_t;

    // per requester slot FSM
    // PENDING waits for grant and ACTIVE owns the memory bus
    // RETIRE is the single busy-low cycle
    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        PENDING = 2'b01,
        ACTIVE  = 2'b10,
        RETIRE  = 2'b11
    } slot_state_e;

endpackage

/* hw/memory_controller.sv */
////////////////////////////////////////////////////////////////////////////
// memory controller top joining the fetch port and the data port
// onto one external memory bus through per port slots and an arbiter
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mem_ctrl_params.svh"

module memory_controller (
    input  logic                   clk,
    input  logic                   rst_n,
    // instruction fetch port
    input  logic                   i_ren,
    input  logic                   i_wen,
    input  mem_ctrl_pkg::addr_t    i_addr,
    input  mem_ctrl_pkg::word_t    i_wdata,
    input  mem_ctrl_pkg::byte_en_t i_byte_en,
    output mem_ctrl_pkg::word_t    i_rdata,
    output logic                   i_busy,
    // data port
    input  logic                   d_ren,
    input  logic                   d_wen,
    input  mem_ctrl_pkg::addr_t    d_addr,
    input  mem_ctrl_pkg::word_t    d_wdata,
    input  mem_ctrl_pkg::byte_en_t d_byte_en,
    output mem_ctrl_pkg::word_t    d_rdata,
    output logic                   d_busy,
    // external memory bus
    output logic                   mem_ren,
    output logic                   mem_wen,
    output mem_ctrl_pkg::addr_t    mem_addr,
    output mem_ctrl_pkg::word_t    mem_wdata,
    output mem_ctrl_pkg::byte_en_t mem_byte_en,
    input  logic                   mem_busy,
    input  mem_ctrl_pkg::word_t    mem_rdata
);
    import mem_ctrl_pkg::*;

    localparam int N         = `MC_NUM_REQ;
    // data sits above fetch in priority
    localparam int INSTR_IDX = 0;
    localparam int DATA_IDX  = 1;

    // requester ports gathered by index
    logic [N-1:0] req_ren;
    logic [N-1:0] req_wen;
    addr_t        req_addr    [N];
    word_t        req_wdata   [N];
    byte_en_t     req_byte_en [N];
    word_t        rsp_rdata   [N];
    logic [N-1:0] rsp_busy;

    // slot to arbiter wires
    logic [N-1:0] slot_req;
    logic [N-1:0] slot_ren;
    logic [N-1:0] slot_wen;
    addr_t        slot_addr    [N];
    word_t        slot_wdata   [N];
    byte_en_t     slot_byte_en [N];
    logic [N-1:0] slot_gnt;
    logic [N-1:0] slot_done;
    word_t        rd_word;

    assign req_ren[INSTR_IDX]     = i_ren;
    assign req_wen[INSTR_IDX]     = i_wen;
    assign req_addr[INSTR_IDX]    = i_addr;
    assign req_wdata[INSTR_IDX]   = i_wdata;
    assign req_byte_en[INSTR_IDX] = i_byte_en;
    assign req_ren[DATA_IDX]      = d_ren;
    assign req_wen[DATA_IDX]      = d_wen;
    assign req_addr[DATA_IDX]     = d_addr;
    assign req_wdata[DATA_IDX]    = d_wdata;
    assign req_byte_en[DATA_IDX]  = d_byte_en;

    assign i_rdata = rsp_rdata[INSTR_IDX];
    assign i_busy  = rsp_busy[INSTR_IDX];
    assign d_rdata = rsp_rdata[DATA_IDX];
    assign d_busy  = rsp_busy[DATA_IDX];

    // one slot per requester
    for (genvar g = 0; g < N; g++) begin : g_slot
        req_slot req_slot_inst (
            .clk          (clk),
            .rst_n        (rst_n),
            .ren          (req_ren[g]),
            .wen          (req_wen[g]),
            .addr         (req_addr[g]),
            .wdata        (req_wdata[g]),
            .byte_en      (req_byte_en[g]),
            .busy         (rsp_busy[g]),
            .rdata        (rsp_rdata[g]),
            .slot_gnt     (slot_gnt[g]),
            .slot_done    (slot_done[g]),
            .rd_word      (rd_word),
            .slot_req     (slot_req[g]),
            .slot_ren     (slot_ren[g]),
            .slot_wen     (slot_wen[g]),
            .slot_addr    (slot_addr[g]),
            .slot_wdata   (slot_wdata[g]),
            .slot_byte_en (slot_byte_en[g])
        );
    end

    bus_arbiter bus_arbiter_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .slot_req     (slot_req),
        .slot_ren     (slot_ren),
        .slot_wen     (slot_wen),
        .slot_addr    (slot_addr),
        .slot_wdata   (slot_wdata),
        .slot_byte_en (slot_byte_en),
        .slot_gnt     (slot_gnt),
        .slot_done    (slot_done),
        .rd_word      (rd_word),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_byte_en  (mem_byte_en),
        .mem_busy     (mem_busy),
        .mem_rdata    (mem_rdata)
    );

endmodule

/* hw/req_slot.sv */
////////////////////////////////////////////////////////////////////////////
// request slot for one core port
// captures a level based access, holds it for the arbiter
// and returns read data with a single busy-low cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mem_ctrl_params.svh"

module req_slot (
    input  logic                  clk,
    input  logic                  rst_n,
    // requester side
    input  logic                  ren,
    input  logic                  wen,
    input  mem_ctrl_pkg::addr_t   addr,
    input  mem_ctrl_pkg::word_t   wdata,
    input  mem_ctrl_pkg::byte_en_t byte_en,
    output logic                  busy,
    output mem_ctrl_pkg::word_t   rdata,
    // arbiter side
    input  logic                  slot_gnt,
    input  logic                  slot_done,
    input  mem_ctrl_pkg::word_t   rd_word,
    output logic                  slot_req,
    output logic                  slot_ren,
    output logic                  slot_wen,
    output mem_ctrl_pkg::addr_t   slot_addr,
    output mem_ctrl_pkg::word_t   slot_wdata,
    output mem_ctrl_pkg::byte_en_t slot_byte_en
);
    import mem_ctrl_pkg::*;

    slot_state_e state;
    slot_state_e state_nxt;
    logic        req_seen;
    logic        capture;

    // any access level from the requester
    assign req_seen = ren | wen;
    // only an idle slot takes a new access
    assign capture  = (state == IDLE) & req_seen;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req_seen) begin
                    state_nxt = PENDING;
                end
            end
            PENDING: begin
                // grant beats a withdraw in the same cycle
                // zero wait memory can finish in the grant cycle
                if (slot_gnt && slot_done) begin
                    state_nxt = RETIRE;
                end else if (slot_gnt) begin
                    state_nxt = ACTIVE;
                end else if (!req_seen) begin
                    // fetch dropped by an interrupt flush
                    state_nxt = IDLE;
                end
            end
            ACTIVE: begin
                // granted accesses always run to completion
                if (slot_done) begin
                    state_nxt = RETIRE;
                end
            end
            RETIRE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            slot_ren <= 1'b0;
            slot_wen <= 1'b0;
        end else begin
            state <= state_nxt;
            if (capture) begin
                // write wins if both levels are up
                slot_ren <= ren & ~wen;
                slot_wen <= wen;
            end
        end
    end

    // captured access payload
    always_ff @(posedge clk) begin
        if (capture) begin
            slot_addr    <= addr;
            slot_wdata   <= wdata;
            slot_byte_en <= byte_en;
        end
        if (slot_done) begin
            rdata <= rd_word;
        end
    end

    // request follows the live levels so a withdraw is never granted
    assign slot_req = (state == PENDING) & req_seen;

    // busy stays high while idle too
    assign busy = (state != RETIRE);

    // arbiter must only grant a waiting slot
    a_gnt_in_pending: assert property (@(posedge clk) disable iff (!rst_n)
        slot_gnt |-> (state == PENDING));

    // one completion gives exactly one busy-low cycle
    a_busy_low_once: assert property (@(posedge clk) disable iff (!rst_n)
        (!busy) == $past(slot_done));

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the memory controller testbench with Verilator
# exits non zero when the build, the run or any check fails

cd "$(dirname "$0")" || exit 1

top=tb_memory_controller
obj=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$top" -Mdir "$obj" -o "$top" -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$obj/$top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$log"; then
    echo "result: fail"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$log"; then
    echo "result: fail, run ended without a verdict"
    exit 1
fi

echo "result: pass"
exit 0

/* sim.f */
+incdir+hw
hw/mem_ctrl_pkg.sv
hw/req_slot.sv
hw/bus_arbiter.sv
hw/memory_controller.sv
tests/tb_clk_gen.sv
tests/tb_memory_controller.sv

/* tests/mem_ctrl_golden.txt */
# port(0 fetch,1 data) op(0 read,1 write,2 abort read) addr wdata byte_en expected mode
# mode: 0 single, 1 issue with next record in the same cycle, 2 single without wait states
1 1 00000100 11111111 f 00000000 0
1 1 00000104 22222222 f 00000000 0
1 1 00000108 33333333 f 00000000 0
1 1 0000010c 44444444 f 00000000 0
1 0 00000100 00000000 f 11111111 0
1 1 00000104 aabbccdd 3 00000000 0
1 0 00000104 00000000 f 2222ccdd 0
1 1 00000108 deadbeef 9 00000000 0
1 0 00000108 00000000 f de3333ef 0
1 1 0000010c 00a5005a 4 00000000 0
1 0 0000010c 00000000 f 44a54444 0
1 1 00000200 00000013 f 00000000 0
1 1 00000204 00100093 f 00000000 0
1 1 00000208 00208113 f 00000000 0
1 1 0000020c fe010113 f 00000000 0
0 0 00000200 00000000 f 00000013 0
0 0 00000204 00000000 f 00100093 0
0 0 00000208 00000000 f 00208113 1
1 0 00000100 00000000 f 11111111 0
1 1 00000110 0badf00d f 00000000 1
0 0 0000020c 00000000 f fe010113 0
1 0 00000104 00000000 f 2222ccdd 1
0 2 000003f0 00000000 f 00000000 0
1 1 00000114 c0ffee00 f 00000000 1
0 2 000003f4 00000000 f 00000000 0
0 0 00000200 00000000 f 00000013 0
1 0 00000110 00000000 f 0badf00d 0
1 0 00000114 00000000 f c0ffee00 2
0 0 00000204 00000000 f 00100093 2
1 1 00000118 12345678 f 00000000 2
1 0 00000118 00000000 f 12345678 2
1 1 00000118 0000ab00 2 00000000 0
0 0 00000208 00000000 f 00208113 1
1 0 00000118 00000000 f 1234ab78 0
1 1 0000011c ffffffff f 00000000 0
1 1 0000011c 00000000 6 00000000 0
1 0 0000011c 00000000 f ff0000ff 0
0 0 0000020c 00000000 f fe010113 0

/* tests/tb_clk_gen.sv */
////////////////////////////////////////////////////////////////////////////
// testbench clock and reset source for the memory controller testbench
// 8 ns clock, active low reset held for the first three cycles
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // release on a falling edge away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* tests/tb_memory_controller.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the memory controller
// replays the golden access list on the fetch and data ports against a
// word memory model with random wait states, checks data, order and busy
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mem_ctrl_params.svh"

module tb_memory_controller;
    import mem_ctrl_pkg::*;

    localparam int MAX_REC     = 64;
    localparam int OP_READ     = 0;
    localparam int OP_WRITE    = 1;
    localparam int OP_ABORT    = 2;
    localparam int MODE_PAIR   = 1;
    localparam int MODE_TIMED  = 2;
    localparam int ABORT_WATCH = 6;
    localparam int MEM_WORDS   = 256;
    localparam int N           = `MC_NUM_REQ;

    logic     clk;
    logic     rst_n;
    // fetch port
    logic     i_ren;
    logic     i_wen;
    addr_t    i_addr;
    word_t    i_wdata;
    byte_en_t i_byte_en;
    word_t    i_rdata;
    logic     i_busy;
    // data port
    logic     d_ren;
    logic     d_wen;
    addr_t    d_addr;
    word_t    d_wdata;
    byte_en_t d_byte_en;
    word_t    d_rdata;
    logic     d_busy;
    // memory bus
    logic     mem_ren;
    logic     mem_wen;
    addr_t    mem_addr;
    word_t    mem_wdata;
    byte_en_t mem_byte_en;
    logic     mem_busy;
    word_t    mem_rdata;

    // golden records
    int       rec_port  [MAX_REC];
    int       rec_op    [MAX_REC];
    addr_t    rec_addr  [MAX_REC];
    word_t    rec_wdata [MAX_REC];
    byte_en_t rec_be    [MAX_REC];
    word_t    rec_exp   [MAX_REC];
    int       rec_mode  [MAX_REC];
    int       num_rec;
    bit       load_ok;
    bit       loaded;

    // memory model state
    word_t    mem_array [MEM_WORDS];
    bit       in_access;
    bit       finishing;
    bit       cur_wen;
    addr_t    cur_addr;
    word_t    cur_wdata;
    byte_en_t cur_be;
    int       waits;
    bit       no_wait;
    integer   seed = 32'hb491bbc3;
    // every address the memory saw in order
    addr_t    bus_log [$];

    // per port tracking of the access in flight
    bit       pending   [N];
    bit       bus_seen  [N];
    addr_t    pend_addr [N];

    int       checks;
    int       errors;

    tb_clk_gen clk_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    memory_controller memory_controller_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_ren       (i_ren),
        .i_wen       (i_wen),
        .i_addr      (i_addr),
        .i_wdata     (i_wdata),
        .i_byte_en   (i_byte_en),
        .i_rdata     (i_rdata),
        .i_busy      (i_busy),
        .d_ren       (d_ren),
        .d_wen       (d_wen),
        .d_addr      (d_addr),
        .d_wdata     (d_wdata),
        .d_byte_en   (d_byte_en),
        .d_rdata     (d_rdata),
        .d_busy      (d_busy),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en),
        .mem_busy    (mem_busy),
        .mem_rdata   (mem_rdata)
    );

    task check_value(input word_t actual, input word_t expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] t=%0d ns: %s, got %h expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task load_golden;
        int       fd;
        int       n;
        int       f_port;
        int       f_op;
        int       f_mode;
        addr_t    f_addr;
        word_t    f_wdata;
        byte_en_t f_be;
        word_t    f_exp;
        string    line;
        num_rec = 0;
        fd      = $fopen("tests/mem_ctrl_golden.txt", "r");
        load_ok = (fd != 0);
        if (load_ok) begin
            while (!$feof(fd) && num_rec < MAX_REC) begin
                n = $fgets(line, fd);
                // skip column notes and blank lines
                if (n > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %h %h %h %h %d", f_port, f_op,
                                f_addr, f_wdata, f_be, f_exp, f_mode);
                    if (n == 7) begin
                        rec_port[num_rec]  = f_port;
                        rec_op[num_rec]    = f_op;
                        rec_addr[num_rec]  = f_addr;
                        rec_wdata[num_rec] = f_wdata;
                        rec_be[num_rec]    = f_be;
                        rec_exp[num_rec]   = f_exp;
                        rec_mode[num_rec]  = f_mode;
                        num_rec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // port 1 drives the data side and port 0 the fetch side
    task drive_port(input int p, input logic ren, input logic wen, input addr_t a,
                    input word_t w, input byte_en_t be);
        if (p == 1) begin
            d_ren     = ren;
            d_wen     = wen;
            d_addr    = a;
            d_wdata   = w;
            d_byte_en = be;
        end else begin
            i_ren     = ren;
            i_wen     = wen;
            i_addr    = a;
            i_wdata   = w;
            i_byte_en = be;
        end
    endtask

    function automatic logic port_busy(input int p);
        return (p == 1) ? d_busy : i_busy;
    endfunction

    function automatic word_t port_rdata(input int p);
        return (p == 1) ? d_rdata : i_rdata;
    endfunction

    task write_word(input addr_t a, input word_t w, input byte_en_t be);
        int b;
        for (b = 0; b < 4; b++) begin
            if (be[b]) begin
                mem_array[a[9:2]][8*b +: 8] = w[8*b +: 8];
            end
        end
    endtask

    task mark_bus_seen(input addr_t a);
        int p;
        for (p = 0; p < N; p++) begin
            if (pending[p] && pend_addr[p] == a) begin
                bus_seen[p] = 1'b1;
            end
        end
    endtask

    // one golden record on its port between two falling edges
    task automatic run_access(input int r);
        int p;
        int op;
        int cyc;
        p  = rec_port[r];
        op = rec_op[r];
        if (op == OP_ABORT) begin
            // let the other port take the bus first
            @(negedge clk);
            drive_port(p, 1'b1, 1'b0, rec_addr[r], '0, rec_be[r]);
            @(negedge clk);
            check_value(port_busy(p), 1, $sformatf("record %0d abort busy", r));
            // interrupt flush drops the fetch
            drive_port(p, 1'b0, 1'b0, rec_addr[r], '0, rec_be[r]);
            repeat (ABORT_WATCH) begin
                @(negedge clk);
                check_value(port_busy(p), 1, $sformatf("record %0d abort busy", r));
            end
        end else begin
            pend_addr[p] = rec_addr[r];
            bus_seen[p]  = 1'b0;
            pending[p]   = 1'b1;
            if (rec_mode[r] == MODE_TIMED) begin
                no_wait = 1'b1;
            end
            drive_port(p, op == OP_READ, op == OP_WRITE, rec_addr[r], rec_wdata[r],
                       rec_be[r]);
            // hold the request until busy drops
            cyc = 0;
            while (port_busy(p)) begin
                @(negedge clk);
                cyc++;
            end
            pending[p] = 1'b0;
            check_value(bus_seen[p], 1, $sformatf("record %0d seen on memory bus", r));
            if (op == OP_READ) begin
                check_value(port_rdata(p), rec_exp[r], $sformatf("record %0d read data", r));
            end
            if (rec_mode[r] == MODE_TIMED) begin
                check_value(cyc, 3, $sformatf("record %0d zero wait latency", r));
                no_wait = 1'b0;
            end
            drive_port(p, 1'b0, 1'b0, '0, '0, '0);
            @(negedge clk);
            check_value(port_busy(p), 1, $sformatf("record %0d busy low once", r));
        end
    endtask

    task automatic run_single(input int r);
        int base;
        base = bus_log.size();
        run_access(r);
        if (rec_op[r] == OP_ABORT) begin
            check_value(bus_log.size() - base, 0, $sformatf("record %0d bus count", r));
        end else begin
            check_value(bus_log.size() - base, 1, $sformatf("record %0d bus count", r));
            if (bus_log.size() > base) begin
                check_value(bus_log[base], rec_addr[r], $sformatf("record %0d bus addr", r));
            end
        end
    endtask

    // both records start on the same falling edge
    task automatic run_pair(input int a, input int b);
        int base;
        int first;
        int second;
        int keep;
        base = bus_log.size();
        fork
            run_access(a);
            run_access(b);
        join
        if (rec_op[a] == OP_ABORT || rec_op[b] == OP_ABORT) begin
            // only the surviving access may reach memory
            keep = (rec_op[a] == OP_ABORT) ? b : a;
            check_value(bus_log.size() - base, 1, $sformatf("record %0d abort bus count", a));
            if (bus_log.size() > base) begin
                check_value(bus_log[base], rec_addr[keep],
                            $sformatf("record %0d bus addr", keep));
            end
        end else begin
            // higher index goes first
            first  = (rec_port[a] > rec_port[b]) ? a : b;
            second = (first == a) ? b : a;
            check_value(bus_log.size() - base, 2, $sformatf("record %0d pair bus count", a));
            if (bus_log.size() >= base + 2) begin
                check_value(bus_log[base], rec_addr[first],
                            $sformatf("record %0d first", first));
                check_value(bus_log[base+1], rec_addr[second],
                            $sformatf("record %0d second", second));
            end
        end
    endtask

    // fill depends on every modeled address bit
    initial begin : mem_fill
        int    k;
        addr_t fill_addr;
        for (k = 0; k < MEM_WORDS; k++) begin
            fill_addr    = addr_t'(k) << 2;
            mem_array[k] = {fill_addr[15:0] ^ 16'h5a5a, ~fill_addr[15:0]};
        end
    end

    // memory model runs on the falling edge
    always @(negedge clk) begin
        // completion happened at the rising edge just passed
        if (finishing) begin
            if (cur_wen) begin
                write_word(cur_addr, cur_wdata, cur_be);
            end
            in_access = 1'b0;
            finishing = 1'b0;
        end
        if (!in_access && (mem_ren || mem_wen)) begin
            in_access = 1'b1;
            cur_wen   = mem_wen;
            cur_addr  = mem_addr;
            cur_wdata = mem_wdata;
            cur_be    = mem_byte_en;
            waits     = no_wait ? 0 : int'($unsigned($random(seed)) % 4);
            bus_log.push_back(mem_addr);
            mark_bus_seen(mem_addr);
        end else if (in_access) begin
            check_value(mem_addr, cur_addr, "memory address held through wait");
            waits = waits - 1;
        end
        if (in_access) begin
            mem_busy = (waits != 0);
            if (waits == 0) begin
                mem_rdata = mem_array[cur_addr[9:2]];
                finishing = 1'b1;
            end
        end else begin
            mem_busy = 1'b1;
        end
    end

    initial begin : watchdog
        wait (loaded == 1'b1);
        repeat (num_rec * 40 + 200) @(posedge clk);
        $display("timeout: run exceeded %0d clock periods", num_rec * 40 + 200);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : main
        int r;
        drive_port(0, 1'b0, 1'b0, '0, '0, '0);
        drive_port(1, 1'b0, 1'b0, '0, '0, '0);
        mem_busy  = 1'b1;
        mem_rdata = '0;
        in_access = 1'b0;
        finishing = 1'b0;
        no_wait   = 1'b0;
        pending   = '{default: 1'b0};
        checks    = 0;
        errors    = 0;
        load_golden();
        loaded = 1'b1;
        if (!load_ok || num_rec == 0) begin
            $display("no records could be read from tests/mem_ctrl_golden.txt");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            wait (rst_n == 1'b1);
            @(negedge clk);
            // reset values
            check_value(i_busy, 1, "fetch busy after reset");
            check_value(d_busy, 1, "data busy after reset");
            check_value(mem_ren, 0, "mem_ren after reset");
            check_value(mem_wen, 0, "mem_wen after reset");
            r = 0;
            while (r < num_rec) begin
                if (rec_mode[r] == MODE_PAIR && r + 1 < num_rec) begin
                    run_pair(r, r + 1);
                    r += 2;
                end else begin
                    run_single(r);
                    r += 1;
                end
            end
            repeat (4) @(negedge clk);
            $display("%0d checks run, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule
